//--- compile.f
source/rv_pkg.sv
source/instruction_fetch.sv
source/instruction_decode.sv
source/register_file.sv
source/execute_unit.sv
source/rv_core.sv
bench/clock_gen.sv
bench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

	logic clk;
	logic por_n;	// from clock_gen
	logic test_rst_n;	// per-test pulse
	logic rst_n;
	logic run;
	logic imem_we;
	logic [imem_aw-1:0] imem_addr;
	logic [31:0] imem_wdata;
	logic [xlen-1:0] pc;
	logic store_valid;
	store_t store;

	logic [31:0] prog [$];	// assembled program
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	store_t got [$];	// stores seen on the pulse output
	integer seed;

	assign rst_n = por_n & test_rst_n;

	clock_gen clock_gen_i (.clk (clk), .rst_n (por_n));

	rv_core dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.run (run),
		.imem_we (imem_we),
		.imem_addr (imem_addr),
		.imem_wdata (imem_wdata),
		.pc (pc),
		.store_valid (store_valid),
		.store (store)
	);

	// rv32i encoders
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};	// sw
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic void put(input logic [31:0] word);
		prog.push_back(word);
	endfunction

	function automatic logic [31:0] here_pc();
		return prog.size() * 4;	// pc of the next word put
	endfunction

	// lui + addi, upper part rounded since addi sign extends
	function automatic void load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		put(u_word(upper[31:12], rd, 7'b0110111));
		put(i_word(value[11:0], rd, 3'b000, rd, 7'b0010011));
	endfunction

	// sw rs2, off(rs1) plus the expected address and data
	function automatic void store_and_expect(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [31:0] base, input logic [11:0] off, input logic [31:0] data);
		put(s_word(off, rs2, rs1));
		exp_addr.push_back(base + {{20{off[11]}}, off});
		exp_data.push_back(data);
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;	// beq
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;	// bgeu
		endcase
	endfunction

	// x10 marker only set on the fall-through path
	function automatic void branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b, input logic [11:0] off);
		put(i_word(12'd0, 5'd0, 3'b000, 5'd10, 7'b0010011));
		put(b_word(13'd8, rs2, rs1, f3));	// skips the marker set
		put(i_word(12'd1, 5'd0, 3'b000, 5'd10, 7'b0010011));
		store_and_expect(5'd10, 5'd0, 32'd0, off, branch_taken(f3, a, b) ? 32'd0 : 32'd1);
	endfunction

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	// load, reset, run, collect the stores, compare
	task automatic run_program(input string name);
		integer cycles;
		logic [31:0] park_pc;
		park_pc = here_pc() - 32'd4;	// self-jump is the last word
		run = 1'b0;
		for (int i = 0; i < prog.size(); i++)
		begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = imem_aw'(i);
			imem_wdata = prog[i];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
		test_rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		test_rst_n = 1'b1;
		run = 1'b1;
		got.delete();
		cycles = 0;
		while (got.size() < exp_addr.size())
		begin
			@(negedge clk);	// pulse is stable mid-cycle
			if (store_valid)
				got.push_back(store);
			cycles++;
			if (cycles > 1000)
			begin
				$display("timeout in %s: no store arrived, %0d of %0d seen", name,
					got.size(), exp_addr.size());
				stop_on_error();
			end
		end
		@(posedge clk);
		#1;
		run = 1'b0;
		// core should sit on its self-jump
		assert (pc == park_pc)
		else
		begin
			$display("** Error %s: pc expected %h, actual %h", name, park_pc, pc);
			stop_on_error();
		end
		for (int k = 0; k < got.size(); k++)
		begin
			assert (got[k].addr == exp_addr[k])
			else
			begin
				$display("** Error %s: store %0d addr expected %h, actual %h", name, k,
					exp_addr[k], got[k].addr);
				stop_on_error();
			end
			assert (got[k].data == exp_data[k])
			else
			begin
				$display("** Error %s: store %0d data expected %h, actual %h", name, k,
					exp_data[k], got[k].data);
				stop_on_error();
			end
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic test_alu();
		logic [31:0] a, b;
		a = 32'hffff_ff9c;	// -100
		b = 32'd37;	// shift amount 5
		load_const(5'd1, a);
		load_const(5'd2, b);
		put(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));	// add
		put(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));	// sub
		put(r_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
		put(r_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
		put(r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
		put(r_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd8));	// sll
		put(r_word(7'h00, 5'd2, 5'd1, 3'b101, 5'd9));	// srl
		put(r_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd11));	// sra
		put(r_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd12));
		put(r_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd13));
		put(i_word(12'd500, 5'd1, 3'b000, 5'd14, 7'b0010011));	// addi
		store_and_expect(5'd3, 5'd0, 32'd0, 12'h100, a + b);
		store_and_expect(5'd4, 5'd0, 32'd0, 12'h104, a - b);
		store_and_expect(5'd5, 5'd0, 32'd0, 12'h108, a & b);
		store_and_expect(5'd6, 5'd0, 32'd0, 12'h10c, a | b);
		store_and_expect(5'd7, 5'd0, 32'd0, 12'h110, a ^ b);
		store_and_expect(5'd8, 5'd0, 32'd0, 12'h114, a << b[4:0]);
		store_and_expect(5'd9, 5'd0, 32'd0, 12'h118, a >> b[4:0]);
		store_and_expect(5'd11, 5'd0, 32'd0, 12'h11c, $signed(a) >>> b[4:0]);
		store_and_expect(5'd12, 5'd0, 32'd0, 12'h120, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		store_and_expect(5'd13, 5'd0, 32'd0, 12'h124, (a < b) ? 32'd1 : 32'd0);
		store_and_expect(5'd14, 5'd0, 32'd0, 12'h128, a + 32'd500);
		put(j_word(21'd0, 5'd0));	// park
		run_program("alu");
	endtask

	task automatic test_upper();
		logic [31:0] auipc_pc;
		put(u_word(20'habcde, 5'd1, 7'b0110111));	// lui
		auipc_pc = here_pc();
		put(u_word(20'h12345, 5'd2, 7'b0010111));
		store_and_expect(5'd1, 5'd0, 32'd0, 12'h200, 32'habcde000);
		store_and_expect(5'd2, 5'd0, 32'd0, 12'h204, auipc_pc + 32'h12345000);
		put(j_word(21'd0, 5'd0));
		run_program("upper immediates");
	endtask

	task automatic test_branches();
		logic [31:0] neg, pos;
		neg = 32'hffff_fffb;	// -5, large when unsigned
		pos = 32'd7;
		load_const(5'd1, neg);
		load_const(5'd2, pos);
		load_const(5'd3, pos);
		branch_case(3'b000, 5'd2, 5'd3, pos, pos, 12'h300);
		branch_case(3'b000, 5'd1, 5'd2, neg, pos, 12'h304);
		branch_case(3'b001, 5'd1, 5'd2, neg, pos, 12'h308);
		branch_case(3'b001, 5'd2, 5'd3, pos, pos, 12'h30c);
		branch_case(3'b100, 5'd1, 5'd2, neg, pos, 12'h310);
		branch_case(3'b100, 5'd2, 5'd1, pos, neg, 12'h314);
		branch_case(3'b101, 5'd2, 5'd1, pos, neg, 12'h318);
		branch_case(3'b101, 5'd1, 5'd2, neg, pos, 12'h31c);
		branch_case(3'b110, 5'd2, 5'd1, pos, neg, 12'h320);
		branch_case(3'b110, 5'd1, 5'd2, neg, pos, 12'h324);
		branch_case(3'b111, 5'd1, 5'd2, neg, pos, 12'h328);
		branch_case(3'b111, 5'd2, 5'd1, pos, neg, 12'h32c);
		put(j_word(21'd0, 5'd0));
		run_program("branches");
	endtask

	task automatic test_jumps();
		logic [31:0] jal_pc, jalr_pc;
		jal_pc = here_pc();
		put(j_word(21'd8, 5'd1));	// jal x1, over the marker
		put(i_word(12'd1, 5'd0, 3'b000, 5'd5, 7'b0010011));
		store_and_expect(5'd1, 5'd0, 32'd0, 12'h400, jal_pc + 32'd4);
		store_and_expect(5'd5, 5'd0, 32'd0, 12'h404, 32'd0);
		put(i_word(12'd35, 5'd0, 3'b000, 5'd6, 7'b0010011));	// 35 + 2 odd, lands on 36
		jalr_pc = here_pc();
		put(i_word(12'd2, 5'd6, 3'b000, 5'd7, 7'b1100111));
		put(i_word(12'd2, 5'd0, 3'b000, 5'd5, 7'b0010011));	// skipped
		put(i_word(12'd3, 5'd0, 3'b000, 5'd5, 7'b0010011));
		put(i_word(12'd4, 5'd0, 3'b000, 5'd5, 7'b0010011));
		store_and_expect(5'd7, 5'd0, 32'd0, 12'h408, jalr_pc + 32'd4);	// word at 36
		store_and_expect(5'd5, 5'd0, 32'd0, 12'h40c, 32'd0);
		put(j_word(21'd0, 5'd0));
		run_program("jumps");
	endtask

	task automatic test_x0_and_offsets();
		put(i_word(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));	// addi x0, x0, 123
		load_const(5'd8, 32'h0000_0400);	// base
		load_const(5'd9, 32'd77);
		store_and_expect(5'd0, 5'd8, 32'h400, 12'hffc, 32'd0);	// -4
		store_and_expect(5'd9, 5'd8, 32'h400, 12'hff0, 32'd77);	// -16
		put(j_word(21'd0, 5'd0));
		run_program("x0 and store offsets");
	endtask

	task automatic test_random_alu();
		logic [31:0] a, b, r;
		integer kind;
		for (int k = 0; k < 20; k++)
		begin
			a = $random(seed);
			b = $random(seed);
			kind = $unsigned($random(seed)) % 3;
			load_const(5'd1, a);
			load_const(5'd2, b);
			case (kind)
				0:
				begin
					put(i_word(b[11:0], 5'd1, 3'b000, 5'd3, 7'b0010011));	// addi, low bits of b
					r = a + {{20{b[11]}}, b[11:0]};
				end
				1:
				begin
					put(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
					r = a + b;
				end
				default:
				begin
					put(r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
					r = a ^ b;
				end
			endcase
			store_and_expect(5'd3, 5'd0, 32'd0, 12'h500 + 12'(k * 4), r);
		end
		put(j_word(21'd0, 5'd0));
		run_program("random alu");
	endtask

	initial
	begin
		integer wait_cycles;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		test_rst_n = 1'b1;
		seed = 25;
		wait_cycles = 0;
		while (por_n !== 1'b1)	// power-on reset release
		begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > 100)
			begin
				$display("timeout: power-on reset was never released");
				stop_on_error();
			end
		end
		test_alu();
		test_upper();
		test_branches();
		test_jumps();
		test_x0_and_offsets();
		test_random_alu();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// power-on reset, low for 16 rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic run,	// level, core steps while high

	// program load
	input logic imem_we,
	input logic [imem_aw-1:0] imem_addr,
	input logic [31:0] imem_wdata,

	output logic [xlen-1:0] pc,
	output logic store_valid,
	output store_t store
	);

	logic [31:0] instr;
	logic [xlen-1:0] next_pc;
	decode_t dec;
	logic [xlen-1:0] rs1_data, rs2_data;
	logic wb_en;
	logic [4:0] wb_addr;
	logic [xlen-1:0] wb_data;

	// fetch, also holds the pc
	instruction_fetch fetch_i (
		.clk (clk),
		.rst_n (rst_n),
		.run (run),
		.imem_we (imem_we),
		.imem_addr (imem_addr),
		.imem_wdata (imem_wdata),
		.next_pc (next_pc),
		.pc (pc),
		.instr (instr)
	);

	instruction_decode decode_i (
		.instruction (instr),
		.dec (dec)
	);

	// operands held between instructions
	register_file regs_i (
		.clk (clk),
		.rst_n (rst_n),
		.rs1_addr (dec.rs1),
		.rs2_addr (dec.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	execute_unit exec_i (
		.clk (clk),
		.rst_n (rst_n),
		.run (run),
		.pc (pc),
		.dec (dec),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.next_pc (next_pc),	// back to fetch
		.wb_en (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.store_valid (store_valid),
		.store (store)
	);

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import rv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic [xlen-1:0] pc,
	input decode_t dec,
	input logic [xlen-1:0] rs1_data,
	input logic [xlen-1:0] rs2_data,

	output logic [xlen-1:0] next_pc,

	// register writeback
	output logic wb_en,
	output logic [4:0] wb_addr,
	output logic [xlen-1:0] wb_data,

	// store pulse, one cycle after the sw executes
	output logic store_valid,
	output store_t store
	);

	logic [xlen-1:0] op_a, op_b;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] branch_target;	// pc + imm
	logic zero;
	logic taken;

	// operand select
	always_comb
	begin
		case (dec.op1_src)
			op1_zero: op_a = '0;
			op1_pc: op_a = pc;
			default: op_a = rs1_data;
		endcase
	end

	assign op_b = dec.op2_src ? dec.immediate : rs2_data;

	always_comb
	begin
		case (dec.alu_op)
			alu_add: alu_result = dec.sign ? op_a - op_b : op_a + op_b;
			alu_sll: alu_result = op_a << op_b[4:0];
			alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor: alu_result = op_a ^ op_b;
			alu_sr: alu_result = dec.sign ? $unsigned($signed(op_a) >>> op_b[4:0])
				: op_a >> op_b[4:0];	// sra or srl
			alu_or: alu_result = op_a | op_b;
			default: alu_result = op_a & op_b;	// alu_and
		endcase
	end

	assign zero = (alu_result == '0);

	// jump, or conditional with matching polarity
	assign taken = dec.jump || (dec.branch && (dec.branch_if_zero == zero));

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + dec.immediate;

	// jal and jalr both get their target from the alu, bit 0 cleared
	always_comb
	begin
		if (dec.jump)
			next_pc = {alu_result[xlen-1:1], 1'b0};
		else if (taken)
			next_pc = branch_target;
		else
			next_pc = pc_plus4;
	end

	assign wb_en = dec.rf_write_en & run;	// nothing retires while halted
	assign wb_addr = dec.rd;
	assign wb_data = dec.link ? pc_plus4 : alu_result;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			store_valid <= 1'b0;
		else
			store_valid <= run & dec.mem_write_en;	// single cycle pulse
	end

	// payload held until the next store
	always_ff @(posedge clk)
	begin
		if (run && dec.mem_write_en)
		begin
			store.addr <= alu_result;	// rs1 + imm
			store.data <= rs2_data;
		end
	end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_pkg::*; (
	input logic clk,
	input logic rst_n,

	// read side, combinational
	input logic [4:0] rs1_addr,
	input logic [4:0] rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,

	// writeback from execute
	input logic wb_en,
	input logic [4:0] wb_addr,
	input logic [xlen-1:0] wb_data
	);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;	// full clear on reset
		end
		else if (wb_en && wb_addr != 5'd0)	// x0 writes dropped
			regs[wb_addr] <= wb_data;
	end

	// x0 forced so it reads zero even before reset
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode import rv_pkg::*; (
	input logic [31:0] instruction,
	output decode_t dec
	);

	opcode_t opcode;
	logic [2:0] funct3;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

	assign opcode = opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];

	// immediate formats, all sign extended from bit 31
	assign imm_i = {{(xlen-12){instruction[31]}}, instruction[31:20]};
	assign imm_s = {{(xlen-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign imm_b = {{(xlen-13){instruction[31]}}, instruction[31], instruction[7],
		instruction[30:25], instruction[11:8], 1'b0};
	assign imm_j = {{(xlen-21){instruction[31]}}, instruction[31], instruction[19:12],
		instruction[20], instruction[30:21], 1'b0};
	assign imm_u = {instruction[31:12], 12'b0};	// upper 20, low bits zero

	always_comb
	begin
		// defaults describe a no-op that falls through to pc+4
		dec = '0;
		dec.rs1 = instruction[19:15];	// fixed field positions
		dec.rs2 = instruction[24:20];
		dec.rd = instruction[11:7];
		dec.op1_src = op1_reg;
		dec.alu_op = alu_add;

		case (opcode)
			op_r:
			begin
				dec.alu_op = alu_op_t'(funct3);
				dec.sign = instruction[30];	// sub, sra
				dec.rf_write_en = 1'b1;
			end

			op_imm:
			begin
				dec.immediate = imm_i;
				dec.op2_src = 1'b1;
				dec.alu_op = alu_op_t'(funct3);
				// only srai looks at bit 30, addi has no subtract form
				dec.sign = (funct3 == 3'b101) ? instruction[30] : 1'b0;
				dec.rf_write_en = 1'b1;
			end

			op_lui:
			begin
				dec.immediate = imm_u;
				dec.op1_src = op1_zero;	// 0 + imm
				dec.op2_src = 1'b1;
				dec.rf_write_en = 1'b1;
			end

			op_auipc:
			begin
				dec.immediate = imm_u;
				dec.op1_src = op1_pc;	// pc + imm
				dec.op2_src = 1'b1;
				dec.rf_write_en = 1'b1;
			end

			op_jal:
			begin
				dec.immediate = imm_j;
				dec.op1_src = op1_pc;	// alu makes the target
				dec.op2_src = 1'b1;
				dec.jump = 1'b1;
				dec.link = 1'b1;
				dec.rf_write_en = 1'b1;
			end

			op_jalr:
			begin
				dec.immediate = imm_i;
				dec.op2_src = 1'b1;	// rs1 + imm
				dec.jump = 1'b1;
				dec.link = 1'b1;
				dec.rf_write_en = 1'b1;
			end

			op_branch:
			begin
				dec.immediate = imm_b;	// target built in execute
				dec.branch = 1'b1;
				case (funct3)
					3'b000, 3'b001:	// beq, bne
					begin
						dec.alu_op = alu_add;
						dec.sign = 1'b1;	// subtract
					end
					3'b100, 3'b101:	// blt, bge
						dec.alu_op = alu_slt;
					3'b110, 3'b111:	// bltu, bgeu
						dec.alu_op = alu_sltu;
					default:	// 010, 011 illegal
						dec.branch = 1'b0;
				endcase
				// taken on zero for beq, bge, bgeu
				case (funct3)
					3'b000, 3'b101, 3'b111:
						dec.branch_if_zero = 1'b1;
					default:
						dec.branch_if_zero = 1'b0;
				endcase
			end

			op_store:
			begin
				dec.immediate = imm_s;
				dec.op2_src = 1'b1;	// address = rs1 + imm
				dec.mem_write_en = 1'b1;
			end

			default:	// load, illegal
			begin
				dec.rf_write_en = 1'b0;
				dec.mem_write_en = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch import rv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic run,

	// program load port
	input logic imem_we,
	input logic [imem_aw-1:0] imem_addr,
	input logic [31:0] imem_wdata,

	input logic [xlen-1:0] next_pc,	// from execute
	output logic [xlen-1:0] pc,
	output logic [31:0] instr
	);

	logic [31:0] imem [imem_depth];	// no reset on the array

	// pc only moves while running
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= '0;
		else if (run)
			pc <= next_pc;
	end

	// load strobe, independent of run
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// async read, word addressed
	assign instr = imem[pc[imem_aw+1:2]];

endmodule

`default_nettype wire

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;	// data width, one word
	localparam int imem_depth = 256;	// instruction words
	localparam int imem_aw = 8;	// word address width of imem

	// rv32i major opcodes
	typedef enum logic [6:0] {
		op_r = 7'b0110011,
		op_imm = 7'b0010011,
		op_load = 7'b0000011,	// decodes as no-op here
		op_jalr = 7'b1100111,
		op_branch = 7'b1100011,
		op_store = 7'b0100011,
		op_jal = 7'b1101111,
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111
	} opcode_t;

	// alu ops follow funct3 encoding
	typedef enum logic [2:0] {
		alu_add = 3'b000,	// add or sub
		alu_sll = 3'b001,
		alu_slt = 3'b010,
		alu_sltu = 3'b011,
		alu_xor = 3'b100,
		alu_sr = 3'b101,	// srl or sra
		alu_or = 3'b110,
		alu_and = 3'b111
	} alu_op_t;

	// first alu operand source
	typedef enum logic [1:0] {
		op1_reg = 2'b00,
		op1_zero = 2'b01,	// lui
		op1_pc = 2'b10	// auipc, jal
	} op1_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [xlen-1:0] immediate;
		op1_t op1_src;
		logic op2_src;	// 0 register, 1 immediate
		alu_op_t alu_op;
		logic sign;	// sub or sra
		logic branch;	// conditional
		logic branch_if_zero;	// condition polarity vs alu zero
		logic jump;	// unconditional
		logic link;	// rd gets pc+4
		logic rf_write_en;
		logic mem_write_en;
	} decode_t;

	// store leaving the core
	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
	} store_t;

endpackage

`default_nettype wire
